// ==== compile.f ====
+incdir+.
flPrFifoPkg.sv
spRam.sv
ramArbiter.sv
flRxWriter.sv
flTxReader.sv
flPrFifo.sv
tbFlPrFifo.sv

// ==== flPrFifo.sv ====
// ----------------------------------------
// Packet-release FIFO for a frame stream
// A frame leaves TX only after its eof is in
// Frames flagged with rxDiscard are dropped
// srcRdy and dstRdy both high moves a word
// ----------------------------------------

`timescale 1ns/10ps
`include "flPrFifo_macros.svh"

module flPrFifo (
  input  logic               CLK,
  input  logic               rst,
  // RX port
  input  flPrFifoPkg::flWord rxWord,
  input  logic               rxSrcRdy,
  input  logic               rxDiscard,
  output logic               rxDstRdy,
  // TX port
  output flPrFifoPkg::flWord txWord,
  output logic               txSrcRdy,
  input  logic               txDstRdy
);
  import flPrFifoPkg::*;

  // Peer requests and grants
  ramReq wrReq;
  ramReq rdReq;
  logic  wrGrant;
  logic  rdGrant;

  // Pointers exchanged between the peers
  ramPtr commitPtr;
  ramPtr readPtr;

  // RAM port
  logic                     ramEn;
  logic                     ramWe;
  logic [`FL_PTR_WIDTH-1:0] ramAddr;
  flWord                    ramWdata;
  flWord                    ramRdata;

  // Read return path
  flWord rdData;
  logic  rdValid;

  // ----------------------------------------
  // Writer and reader peers
  // ----------------------------------------
  flRxWriter writer (
    .CLK       (CLK),
    .rst       (rst),
    .rxWord    (rxWord),
    .rxSrcRdy  (rxSrcRdy),
    .rxDiscard (rxDiscard),
    .rxDstRdy  (rxDstRdy),
    .wrReq     (wrReq),
    .wrGrant   (wrGrant),
    .readPtr   (readPtr),
    .commitPtr (commitPtr)
  );

  flTxReader reader (
    .CLK       (CLK),
    .rst       (rst),
    .rdReq     (rdReq),
    .rdGrant   (rdGrant),
    .rdData    (rdData),
    .rdValid   (rdValid),
    .commitPtr (commitPtr),
    .readPtr   (readPtr),
    .txWord    (txWord),
    .txSrcRdy  (txSrcRdy),
    .txDstRdy  (txDstRdy)
  );

  // ----------------------------------------
  // Shared memory
  // ----------------------------------------
  ramArbiter arbiter (
    .CLK      (CLK),
    .rst      (rst),
    .wrReq    (wrReq),
    .rdReq    (rdReq),
    .wrGrant  (wrGrant),
    .rdGrant  (rdGrant),
    .ramEn    (ramEn),
    .ramWe    (ramWe),
    .ramAddr  (ramAddr),
    .ramWdata (ramWdata),
    .ramRdata (ramRdata),
    .rdData   (rdData),
    .rdValid  (rdValid)
  );

  spRam ram (
    .CLK      (CLK),
    .ramEn    (ramEn),
    .ramWe    (ramWe),
    .ramAddr  (ramAddr),
    .ramWdata (ramWdata),
    .ramRdata (ramRdata)
  );

endmodule

// ==== flPrFifoPkg.sv ====
// ----------------------------------------
// Types shared by the FIFO blocks
// All flags are active high
// drem is meaningful only on an eof word
// ----------------------------------------

`include "flPrFifo_macros.svh"

package flPrFifoPkg;

  // ----------------------------------------
  // Frame word, also the RAM word
  // ----------------------------------------
  typedef struct packed {
    logic [`FL_DATA_WIDTH-1:0] data;
    // Index of the last valid byte
    logic [`FL_DREM_WIDTH-1:0] drem;
    logic                      sof;
    logic                      eof;
  } flWord;

  // ----------------------------------------
  // RAM pointer with wrap bit
  // ----------------------------------------
  // Equal addresses with different wrap bits mean full
  typedef struct packed {
    logic                     wrap;
    logic [`FL_PTR_WIDTH-1:0] addr;
  } ramPtr;

  // One access request toward the arbiter
  typedef struct packed {
    logic                     req;
    logic                     we;
    logic [`FL_PTR_WIDTH-1:0] addr;
    // Ignored by the RAM on reads
    flWord                    wdata;
  } ramReq;

endpackage

// ==== flPrFifo_macros.svh ====
// ----------------------------------------
// Sizing of the packet-release FIFO
// FL_RAM_DEPTH must be a power of two
// A frame must fit in FL_RAM_DEPTH words
// ----------------------------------------

`ifndef FL_PR_FIFO_MACROS_SVH
`define FL_PR_FIFO_MACROS_SVH

// Data bits carried by one frame word
`define FL_DATA_WIDTH 32

// Last valid byte index within the word
`define FL_DREM_WIDTH 2

// Words of frame storage
`define FL_RAM_DEPTH 64
`define FL_PTR_WIDTH ($clog2(`FL_RAM_DEPTH))

`endif

// ==== flRxWriter.sv ====
// ----------------------------------------
// RX side of the packet-release FIFO
// rxDiscard is sampled only with the eof word
// A frame longer than FL_RAM_DEPTH stalls RX
// One word staged, one RAM write per grant
// ----------------------------------------

`timescale 1ns/10ps
`include "flPrFifo_macros.svh"

module flRxWriter (
  input  logic               CLK,
  input  logic               rst,
  input  flPrFifoPkg::flWord rxWord,
  input  logic               rxSrcRdy,
  input  logic               rxDiscard,
  output logic               rxDstRdy,
  output flPrFifoPkg::ramReq wrReq,
  input  logic               wrGrant,
  input  flPrFifoPkg::ramPtr readPtr,
  output flPrFifoPkg::ramPtr commitPtr
);
  import flPrFifoPkg::*;

  localparam logic [`FL_PTR_WIDTH:0] ramDepth = (`FL_PTR_WIDTH + 1)'(`FL_RAM_DEPTH);

  // Staging register
  flWord stageWord;
  logic  stageValid;
  logic  stageDiscard;

  // Write side pointers
  ramPtr wrPtr;
  ramPtr wrPtrNext;

  logic                   running;
  logic [`FL_PTR_WIDTH:0] usedCnt;
  logic [`FL_PTR_WIDTH:0] needCnt;
  logic                   accept;

  // ----------------------------------------
  // Space test
  // ----------------------------------------
  // Words held in RAM, committed or not
  assign usedCnt = wrPtr - readPtr;
  // Staged word still needs its own slot
  assign needCnt = usedCnt + (`FL_PTR_WIDTH + 1)'(stageValid);

  // Stage free now or emptied by this cycle's write
  assign rxDstRdy = running && (!stageValid || wrGrant) && (needCnt < ramDepth);
  assign accept = rxSrcRdy && rxDstRdy;

  assign wrPtrNext = ramPtr'(wrPtr + (`FL_PTR_WIDTH + 1)'(1));

  // ----------------------------------------
  // RAM write request
  // ----------------------------------------
  always_comb begin
    wrReq.req = stageValid;
    wrReq.we = 1'b1;
    wrReq.addr = wrPtr.addr;
    wrReq.wdata = stageWord;
  end

  // Payload of the staged word
  always_ff @(posedge CLK) begin
    if (accept) begin
      stageWord <= rxWord;
      // Discard flag only counts on the last word
      stageDiscard <= rxWord.eof && rxDiscard;
    end
  end

  // ----------------------------------------
  // Pointers and commit
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (rst) begin
      running <= 1'b0;
      stageValid <= 1'b0;
      wrPtr <= '0;
      commitPtr <= '0;
    end else begin
      // RX opens one cycle after reset
      running <= 1'b1;
      if (accept) begin
        stageValid <= 1'b1;
      end else if (wrGrant) begin
        stageValid <= 1'b0;
      end
      if (wrGrant) begin
        if (stageDiscard) begin
          // Drop the whole frame
          wrPtr <= commitPtr;
        end else begin
          wrPtr <= wrPtrNext;
        end
        // Frame end releases the frame to the reader
        if (stageWord.eof && !stageDiscard) begin
          commitPtr <= wrPtrNext;
        end
      end
    end
  end

endmodule

// ==== flTxReader.sv ====
// ----------------------------------------
// TX side of the packet-release FIFO
// Reads only committed words
// Two-word output buffer, oldest word on TX
// At most two reads in flight or buffered
// ----------------------------------------

`timescale 1ns/10ps
`include "flPrFifo_macros.svh"

module flTxReader (
  input  logic               CLK,
  input  logic               rst,
  output flPrFifoPkg::ramReq rdReq,
  input  logic               rdGrant,
  input  flPrFifoPkg::flWord rdData,
  input  logic               rdValid,
  input  flPrFifoPkg::ramPtr commitPtr,
  output flPrFifoPkg::ramPtr readPtr,
  output flPrFifoPkg::flWord txWord,
  output logic               txSrcRdy,
  input  logic               txDstRdy
);
  import flPrFifoPkg::*;

  // Slot 0 is the head
  flWord      bufWord [2];
  logic [1:0] bufCnt;
  logic [1:0] nextCnt;

  logic pop;
  logic pending;

  // ----------------------------------------
  // TX port
  // ----------------------------------------
  assign txWord = bufWord[0];
  assign txSrcRdy = bufCnt != 2'd0;
  assign pop = txSrcRdy && txDstRdy;

  // Committed words not read yet
  assign pending = readPtr != commitPtr;

  // Occupancy after this cycle
  // rdValid is the read granted last cycle
  assign nextCnt = bufCnt + {1'b0, rdValid} - {1'b0, pop};

  // ----------------------------------------
  // RAM read request
  // ----------------------------------------
  always_comb begin
    // A grant now lands in the buffer two edges later
    rdReq.req = pending && (nextCnt < 2'd2);
    rdReq.we = 1'b0;
    rdReq.addr = readPtr.addr;
    rdReq.wdata = '0;
  end

  // Read pointer moves on each granted read
  always_ff @(posedge CLK) begin
    if (rst) begin
      readPtr <= '0;
    end else if (rdGrant) begin
      readPtr <= ramPtr'(readPtr + (`FL_PTR_WIDTH + 1)'(1));
    end
  end

  // ----------------------------------------
  // Output buffer
  // ----------------------------------------
  always_ff @(posedge CLK) begin
    if (rst) begin
      bufCnt <= 2'd0;
    end else begin
      bufCnt <= nextCnt;
    end
  end

  always_ff @(posedge CLK) begin
    // Shift toward the head on a pop
    if (pop) begin
      bufWord[0] <= bufWord[1];
    end
    // Returned word goes behind the survivors
    if (rdValid) begin
      if (nextCnt == 2'd1) begin
        bufWord[0] <= rdData;
      end else begin
        bufWord[1] <= rdData;
      end
    end
  end

endmodule

// ==== ramArbiter.sv ====
// ----------------------------------------
// Round-robin owner of the single RAM port
// Grant is combinational in the request cycle
// rdValid follows a granted read by one cycle
// ----------------------------------------

`timescale 1ns/10ps
`include "flPrFifo_macros.svh"

module ramArbiter (
  input  logic                     CLK,
  input  logic                     rst,
  input  flPrFifoPkg::ramReq       wrReq,
  input  flPrFifoPkg::ramReq       rdReq,
  output logic                     wrGrant,
  output logic                     rdGrant,
  output logic                     ramEn,
  output logic                     ramWe,
  output logic [`FL_PTR_WIDTH-1:0] ramAddr,
  output flPrFifoPkg::flWord       ramWdata,
  input  flPrFifoPkg::flWord       ramRdata,
  output flPrFifoPkg::flWord       rdData,
  output logic                     rdValid
);

  // Set when the reader was served last
  logic lastRd;

  // ----------------------------------------
  // Grant
  // ----------------------------------------
  // On a tie the peer not served last wins
  assign wrGrant = wrReq.req && (!rdReq.req || lastRd);
  assign rdGrant = rdReq.req && (!wrReq.req || !lastRd);

  // RAM port mux
  assign ramEn = wrGrant || rdGrant;
  assign ramWe = wrGrant ? wrReq.we : rdReq.we;
  assign ramAddr = wrGrant ? wrReq.addr : rdReq.addr;
  assign ramWdata = wrGrant ? wrReq.wdata : rdReq.wdata;

  // Registered RAM output passes straight through
  assign rdData = ramRdata;

  always_ff @(posedge CLK) begin
    if (rst) begin
      lastRd <= 1'b0;
      rdValid <= 1'b0;
    end else begin
      if (wrGrant) begin
        lastRd <= 1'b0;
      end else if (rdGrant) begin
        lastRd <= 1'b1;
      end
      rdValid <= ramEn && !ramWe;
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the packet-release FIFO testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

verilator --binary --timing -j 0 --top-module tbFlPrFifo -f compile.f \
  -o simTb > "$BUILD_LOG" 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Build failed with status $status"
  exit 1
fi

./obj_dir/simTb > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "RESULT: FAIL" "$SIM_LOG"; then
  exit 1
fi
if ! grep -q "RESULT: PASS" "$SIM_LOG"; then
  echo "No result line in $SIM_LOG"
  exit 1
fi
exit 0

// ==== spRam.sv ====
// ----------------------------------------
// Single-port RAM of frame words
// Read data valid one cycle after the read
// Contents undefined after power-up
// ----------------------------------------

`timescale 1ns/10ps
`include "flPrFifo_macros.svh"

module spRam (
  input  logic                     CLK,
  input  logic                     ramEn,
  input  logic                     ramWe,
  input  logic [`FL_PTR_WIDTH-1:0] ramAddr,
  input  flPrFifoPkg::flWord       ramWdata,
  output flPrFifoPkg::flWord       ramRdata
);
  import flPrFifoPkg::*;

  flWord mem [`FL_RAM_DEPTH];

  // Write or registered read, one per cycle
  always_ff @(posedge CLK) begin
    if (ramEn) begin
      if (ramWe) begin
        mem[ramAddr] <= ramWdata;
      end else begin
        ramRdata <= mem[ramAddr];
      end
    end
  end

endmodule

// ==== tbFlPrFifo.sv ====
// ----------------------------------------
// Testbench for the packet-release FIFO
// Random frames from a fixed seed
// Queue model commits a frame on its eof
// Inputs change 1 ns after the rising edge
// ----------------------------------------

`timescale 1ns/10ps
`include "flPrFifo_macros.svh"

module tbFlPrFifo;
  import flPrFifoPkg::*;

  localparam int numFrames = 60;
  localparam int fullFrames = 12;
  localparam int fullLen = 8;

  logic  CLK = 1'b0;
  logic  rst;
  flWord rxWord;
  logic  rxSrcRdy;
  logic  rxDiscard;
  logic  rxDstRdy;
  flWord txWord;
  logic  txSrcRdy;
  logic  txDstRdy;

  // Stimulus words and the discard flag of their frame
  flWord stimQ [$];
  logic  stimDisc [$];
  // Words of the frame being accepted, and committed words
  flWord frameBuf [$];
  flWord modelQ [$];

  integer seed;
  int     errCount = 0;
  int     checkTotal = 0;
  int     cycleCount = 0;
  int     cycleLimit = 0;
  // TX mode 0 stalled, 1 random gaps, 2 always ready
  int     txMode;
  int     rxRate;
  int     stallLeft;
  // Per-test counters
  int     framesOut;
  int     wordsOut;
  int     acceptedWords;

  flPrFifo dut (
    .CLK       (CLK),
    .rst       (rst),
    .rxWord    (rxWord),
    .rxSrcRdy  (rxSrcRdy),
    .rxDiscard (rxDiscard),
    .rxDstRdy  (rxDstRdy),
    .txWord    (txWord),
    .txSrcRdy  (txSrcRdy),
    .txDstRdy  (txDstRdy)
  );

  always #4 CLK = ~CLK;

  always @(posedge CLK) begin
    cycleCount <= cycleCount + 1;
  end

  // Watchdog
  initial begin
    wait (cycleLimit > 0);
    wait (cycleCount >= cycleLimit);
    $display("Timeout: run stopped after %0d cycles", cycleCount);
    $display("RESULT: FAIL");
    $finish;
  end

  // ----------------------------------------
  // Compare tasks
  // ----------------------------------------
  task automatic checkWord(input string name, input flWord got, input flWord exp);
    checkTotal++;
    if (got !== exp) begin
      errCount++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkFlag(input string name, input logic got, input logic exp);
    checkTotal++;
    if (got !== exp) begin
      errCount++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic checkCount(input string name, input int got, input int exp);
    checkTotal++;
    if (got != exp) begin
      errCount++;
      $display("FAIL %s got %h expected %h", name, got, exp);
    end
  endtask

  function automatic int randBelow(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  // Queue one frame of random words
  task automatic genFrame(input int len, input logic disc);
    flWord w;
    for (int i = 0; i < len; i++) begin
      w.data = $random(seed);
      w.drem = (i == len - 1) ? 2'(randBelow(4)) : 2'd0;
      w.sof = (i == 0);
      w.eof = (i == len - 1);
      stimQ.push_back(w);
      stimDisc.push_back(disc);
    end
  endtask

  task automatic clearCounts();
    framesOut = 0;
    wordsOut = 0;
    acceptedWords = 0;
  endtask

  task automatic reportTest(input string name, input int errBefore);
    $display("test %s: %0d errors", name, errCount - errBefore);
  endtask

  // ----------------------------------------
  // One clock cycle of drive and check
  // ----------------------------------------
  task automatic stepCycle();
    @(posedge CLK);
    #1;
    if (stimQ.size() > 0 && randBelow(100) < rxRate) begin
      rxSrcRdy = 1'b1;
      rxWord = stimQ[0];
      rxDiscard = stimDisc[0];
    end else begin
      rxSrcRdy = 1'b0;
      rxDiscard = 1'b0;
    end
    if (txMode == 0) begin
      txDstRdy = 1'b0;
    end else if (txMode == 2) begin
      txDstRdy = 1'b1;
    end else if (stallLeft > 0) begin
      txDstRdy = 1'b0;
      stallLeft--;
    end else if (randBelow(100) < 8) begin
      // Idle stretch on TX
      stallLeft = 1 + randBelow(12);
      txDstRdy = 1'b0;
    end else begin
      txDstRdy = randBelow(100) < 85;
    end
    @(negedge CLK);
    // TX first, so a word never meets its own frame's commit
    if (txSrcRdy === 1'b1) begin
      if (modelQ.size() == 0) begin
        errCount++;
        $display("Word offered on TX while no committed frame is waiting");
      end else if (txDstRdy) begin
        checkWord("txWord", txWord, modelQ[0]);
        void'(modelQ.pop_front());
      end
      // Count what the DUT actually hands over
      if (txDstRdy) begin
        wordsOut++;
        if (txWord.eof === 1'b1) begin
          framesOut++;
        end
      end
    end
    if (rxSrcRdy && rxDstRdy === 1'b1) begin
      frameBuf.push_back(stimQ[0]);
      acceptedWords++;
      if (stimQ[0].eof) begin
        // Commit or drop the whole frame
        if (!stimDisc[0]) begin
          foreach (frameBuf[i]) begin
            modelQ.push_back(frameBuf[i]);
          end
        end
        frameBuf.delete();
      end
      void'(stimQ.pop_front());
      void'(stimDisc.pop_front());
    end
  endtask

  // ----------------------------------------
  // Test sequence
  // ----------------------------------------
  initial begin
    int   len;
    logic disc;
    int   keptFrames;
    int   keptWords;
    int   dropFrames;
    int   trafficWords;
    int   errBefore;
    int   stallRun;

    seed = 32'h35bf8356;
    rst = 1'b1;
    rxWord = '0;
    rxSrcRdy = 1'b0;
    rxDiscard = 1'b0;
    txDstRdy = 1'b0;
    txMode = 0;
    rxRate = 0;
    stallLeft = 0;
    keptFrames = 0;
    keptWords = 0;
    dropFrames = 0;
    trafficWords = 0;
    clearCounts();

    // Frames for the random traffic test, about one in six dropped
    for (int f = 0; f < numFrames; f++) begin
      len = 1 + randBelow(12);
      disc = (randBelow(6) == 0);
      genFrame(len, disc);
      trafficWords += len;
      if (disc) begin
        dropFrames++;
      end else begin
        keptFrames++;
        keptWords += len;
      end
    end
    cycleLimit = 20 * (trafficWords + fullFrames * fullLen) + 200;

    // Reset for 3 cycles
    errBefore = errCount;
    @(posedge CLK);
    @(negedge CLK);
    checkFlag("rxDstRdy", rxDstRdy, 1'b0);
    checkFlag("txSrcRdy", txSrcRdy, 1'b0);
    @(posedge CLK);
    @(posedge CLK);
    #1 rst = 1'b0;
    @(posedge CLK);
    @(negedge CLK);
    checkFlag("txSrcRdy", txSrcRdy, 1'b0);
    checkFlag("rxDstRdy", rxDstRdy, 1'b1);
    reportTest("reset", errBefore);

    // Random traffic with discard and TX back-pressure
    errBefore = errCount;
    rxRate = 70;
    txMode = 1;
    while (stimQ.size() > 0 || modelQ.size() > 0) begin
      stepCycle();
    end
    // Nothing more may leave TX
    txMode = 2;
    repeat (20) stepCycle();
    checkFlag("discarded frames present", dropFrames > 0, 1'b1);
    checkCount("framesOut", framesOut, keptFrames);
    checkCount("wordsOut", wordsOut, keptWords);
    reportTest("traffic", errBefore);

    // Fill the RAM with TX stalled, then drain
    errBefore = errCount;
    clearCounts();
    for (int f = 0; f < fullFrames; f++) begin
      genFrame(fullLen, 1'b0);
    end
    txMode = 0;
    rxRate = 100;
    stallRun = 0;
    while (stallRun < 8) begin
      stepCycle();
      if (rxSrcRdy && rxDstRdy === 1'b0) begin
        stallRun++;
      end else begin
        stallRun = 0;
      end
    end
    // RAM words plus the two-word TX buffer
    checkCount("words held while TX stalled", acceptedWords, `FL_RAM_DEPTH + 2);
    txMode = 1;
    rxRate = 70;
    while (stimQ.size() > 0 || modelQ.size() > 0) begin
      stepCycle();
    end
    txMode = 2;
    repeat (20) stepCycle();
    checkCount("framesOut", framesOut, fullFrames);
    checkCount("wordsOut", wordsOut, fullFrames * fullLen);
    reportTest("full", errBefore);

    $display("tests 3, checks %0d, errors %0d", checkTotal, errCount);
    if (errCount == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule
